// ==== vlog.f ====
design/lke_pkg.sv
design/lke_action_ram.sv
design/lke_phv_pipe.sv
design/lke_ctrl_parser.sv
design/lke_action_lookup.sv
testbench/tb_clk_gen.sv
testbench/lke_properties.sv
testbench/lke_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
verilator --binary --timing --assert -f vlog.f --top-module lke_tb -o lke_sim \
    && ./obj_dir/lke_sim \
    || { echo "run failed"; exit 1; }

// ==== testbench/lke_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lke_tb;

    import lke_pkg::*;

    localparam int max_cycles = 2000;
    localparam int wait_limit = 20;

    logic                  clk;
    logic                  rst_n;
    phv_t                  phv_in;
    logic                  phv_valid;
    logic [act_addr_w-1:0] match_addr;
    logic                  if_match;
    logic                  ready_out;
    act_entry_t            action;
    logic                  action_valid;
    phv_t                  phv_out;
    logic                  ready_in;
    ctrl_beat_t            c_s;
    ctrl_beat_t            c_m;

    int                     cycle;
    logic [ctrl_data_w-1:0] pkt[$];
    ctrl_beat_t             in_q[$];
    ctrl_beat_t             out_q[$];
    int                     in_t[$];
    int                     out_t[$];
    act_entry_t             entry_3;
    act_entry_t             entry_9;

    tb_clk_gen u_clk_gen (.clk(clk));

    lke_action_lookup u_lke_action_lookup (.*);

    // ==================================================
    // timeout and control stream monitor
    // ==================================================
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            stop_on_error($sformatf("timeout, run exceeded %0d cycles", max_cycles));
        end
    end

    always @(negedge clk) begin
        if (rst_n && c_s.valid) begin
            in_q.push_back(c_s);
            in_t.push_back(cycle);
        end
        if (rst_n && c_m.valid) begin
            out_q.push_back(c_m);
            out_t.push_back(cycle);
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_action(input act_entry_t got, input act_entry_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s action %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_phv(input phv_t got, input phv_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s phv_out differs from sent PHV", $time, what));
        end
    endtask

    task automatic check_beat(input ctrl_beat_t got, input ctrl_beat_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at %0t: %s segment %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    function automatic logic [ctrl_data_w-1:0] rand_seg();
        logic [ctrl_data_w-1:0] v;
        for (int i = 0; i < 8; i++) begin
            v[32*i +: 32] = $urandom;
        end
        return v;
    endfunction

    function automatic phv_t rand_phv();
        phv_t v;
        for (int i = 0; i < 4; i++) begin
            v[256*i +: 256] = rand_seg();
        end
        return v;
    endfunction

    // shifts bytes in from the bottom, so byte 0 ends on top
    function automatic logic [ctrl_data_w-1:0] byte_rev(input logic [ctrl_data_w-1:0] d);
        logic [ctrl_data_w-1:0] r;
        r = '0;
        for (int i = 0; i < 32; i++) begin
            r = {r[ctrl_data_w-9:0], d[8*i +: 8]};
        end
        return r;
    endfunction

    function automatic logic [ctrl_data_w-1:0] build_hdr(input logic [4:0] stg,
                                                         input logic [15:0] flag,
                                                         input logic [7:0] index);
        ctrl_hdr_t h;
        h = ctrl_hdr_t'(rand_seg());
        h.mod_id       = {stg, 3'd2};
        h.control_flag = flag;
        h.resv         = 4'h5;
        h.index        = index;
        return h;
    endfunction

    task automatic build_pkt(input logic [4:0] stg, input logic [15:0] flag,
                             input logic [7:0] index, input int n_segs,
                             output act_entry_t exp);
        logic [ctrl_data_w-1:0] s2;
        logic [ctrl_data_w-1:0] s3;
        logic [ctrl_data_w-1:0] s4;
        pkt.delete();
        pkt.push_back(rand_seg());
        pkt.push_back(build_hdr(stg, flag, index));
        for (int i = 2; i < n_segs; i++) begin
            pkt.push_back(rand_seg());
        end
        exp = '0;
        if (n_segs == 5) begin
            s2  = byte_rev(pkt[2]);
            s3  = byte_rev(pkt[3]);
            s4  = byte_rev(pkt[4]);
            exp = {s2, s3, s4[255:143]};
        end
    endtask

    task automatic send_pkt();
        ctrl_beat_t b;
        foreach (pkt[i]) begin
            b.data  = pkt[i];
            b.user  = {$urandom, $urandom, $urandom, $urandom};
            b.keep  = '1;
            b.last  = (i == pkt.size() - 1);
            b.valid = 1'b1;
            @(posedge clk);
            c_s <= b;
        end
        @(posedge clk);
        c_s <= '0;
        repeat (3) @(posedge clk);
    endtask

    task automatic send_phv(input phv_t phv, input logic [3:0] addr, input logic hit);
        @(posedge clk);
        phv_in     <= phv;
        match_addr <= addr;
        if_match   <= hit;
        phv_valid  <= 1'b1;
        @(posedge clk);
        phv_valid  <= 1'b0;
    endtask

    task automatic wait_action(output int n);
        for (n = 1; n <= wait_limit; n++) begin
            @(negedge clk);
            if (action_valid) begin
                return;
            end
        end
        stop_on_error("action_valid never rose after a PHV was sent");
    endtask

    task automatic lookup(input phv_t phv, input logic [3:0] addr, input logic hit,
                          input act_entry_t exp, input string what);
        int n;
        send_phv(phv, addr, hit);
        wait_action(n);
        if (n != 2) begin
            stop_on_error($sformatf("Fail at %0t: %s action after %0d cycles", $time, what, n));
        end
        check_action(action, exp, what);
        check_phv(phv_out, phv, what);
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_reset_state();
        repeat (4) begin
            @(negedge clk);
            check_bit(action_valid, 1'b0, "action_valid after reset");
            check_bit(c_m.valid, 1'b0, "c_m.valid after reset");
            check_bit(ready_out, 1'b1, "ready_out after reset");
        end
    endtask

    task automatic test_table_write();
        build_pkt(5'd0, 16'hf2f1, 8'h03, 5, entry_3);
        send_pkt();
        // upper index bits are ignored
        build_pkt(5'd0, 16'hf2f1, 8'h29, 5, entry_9);
        send_pkt();
        check_bit(out_q.size() == 0, 1'b1, "no c_m output for writes");
        lookup(rand_phv(), 4'd3, 1'b1, entry_3, "hit at 3");
        lookup(rand_phv(), 4'd9, 1'b1, entry_9, "hit at 9");
    endtask

    task automatic test_miss();
        lookup(rand_phv(), 4'd3, 1'b0, 625'h3f, "miss");
    endtask

    task automatic test_backpressure();
        phv_t phv;
        int   n;
        phv = rand_phv();
        @(posedge clk);
        ready_in <= 1'b0;
        send_phv(phv, 4'd9, 1'b1);
        repeat (2) begin
            @(negedge clk);
            check_bit(action_valid, 1'b0, "action_valid while stalled");
        end
        check_bit(ready_out, 1'b0, "ready_out while halted");
        // a new address must not disturb the latched action
        @(posedge clk);
        match_addr <= 4'd3;
        repeat (4) begin
            @(negedge clk);
            check_bit(action_valid, 1'b0, "action_valid while stalled");
            check_bit(ready_out, 1'b0, "ready_out while stalled");
        end
        @(posedge clk);
        ready_in <= 1'b1;
        wait_action(n);
        if (n != 2) begin
            stop_on_error($sformatf("Fail at %0t: action after stall took %0d cycles", $time, n));
        end
        check_action(action, entry_9, "after stall");
        check_phv(phv_out, phv, "after stall");
        @(negedge clk);
        check_bit(action_valid, 1'b0, "single action_valid after stall");
    endtask

    task automatic test_forward(input logic [4:0] stg, input logic [15:0] flag,
                                input int n_segs, input string what);
        act_entry_t ignored;
        @(posedge clk);
        in_q.delete();
        in_t.delete();
        out_q.delete();
        out_t.delete();
        build_pkt(stg, flag, 8'h03, n_segs, ignored);
        send_pkt();
        check_bit(out_q.size() == n_segs, 1'b1, {what, " forwarded segment count"});
        foreach (in_q[i]) begin
            check_beat(out_q[i], in_q[i], what);
            if (out_t[i] - in_t[i] != 2) begin
                stop_on_error($sformatf("Fail at %0t: %s segment %0d delayed %0d cycles",
                                        $time, what, i, out_t[i] - in_t[i]));
            end
        end
    endtask

    initial begin
        int seed;
        seed = 9687;
        rst_n      <= 1'b0;
        phv_in     <= '0;
        phv_valid  <= 1'b0;
        match_addr <= '0;
        if_match   <= 1'b0;
        ready_in   <= 1'b1;
        c_s        <= '0;
        void'($urandom(seed));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_table_write();
        test_miss();
        test_backpressure();
        test_forward(5'd0, 16'h1234, 3, "bad flag");
        test_forward(5'd1, 16'hf2f1, 5, "wrong stage");
        lookup(rand_phv(), 4'd3, 1'b1, entry_3, "hit at 3 after forward");
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/lke_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module lke_properties (
    input logic                clk,
    input logic                rst_n,
    input logic                phv_valid,
    input logic                ready_in,
    input logic                ready_out,
    input logic                action_valid,
    input lke_pkg::ctrl_beat_t c_m
);

    // one action strobe per item
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        action_valid |=> !action_valid)
        else $error("action_valid high on two consecutive cycles");

    // halt only after a capture or a stalled engine
    a_ready_drop: assert property (@(posedge clk) disable iff (!rst_n)
        !ready_out |-> ($past(phv_valid) || !$past(ready_in)))
        else $error("ready_out low without a preceding phv_valid or low ready_in");

    a_ctrl_reset: assert property (@(posedge clk) !rst_n |-> !c_m.valid)
        else $error("c_m.valid high during reset");

endmodule

bind lke_action_lookup lke_properties u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .phv_valid    (phv_valid),
    .ready_in     (ready_in),
    .ready_out    (ready_out),
    .action_valid (action_valid),
    .c_m          (c_m)
);

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== design/lke_action_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module lke_action_lookup (
    input  logic                            clk,
    input  logic                            rst_n,

    // from the key extractor
    input  lke_pkg::phv_t                   phv_in,
    input  logic                            phv_valid,
    input  logic [lke_pkg::act_addr_w-1:0]  match_addr,
    input  logic                            if_match,
    output logic                            ready_out,

    // to the action engine
    output lke_pkg::act_entry_t             action,
    output logic                            action_valid,
    output lke_pkg::phv_t                   phv_out,
    input  logic                            ready_in,

    // control stream
    input  lke_pkg::ctrl_beat_t             c_s,
    output lke_pkg::ctrl_beat_t             c_m
);

    import lke_pkg::*;

    act_wr_t    act_wr;
    act_entry_t rd_data;

    // ==================================================
    // lookup path
    // ==================================================
    lke_phv_pipe u_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_in       (phv_in),
        .phv_valid    (phv_valid),
        .if_match     (if_match),
        .rd_data      (rd_data),
        .ready_in     (ready_in),
        .ready_out    (ready_out),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out)
    );

    // read at the same edge the PHV is captured
    lke_action_ram u_ram (
        .clk     (clk),
        .act_wr  (act_wr),
        .rd_addr (match_addr),
        .rd_data (rd_data)
    );

    // ==================================================
    // control path
    // ==================================================
    lke_ctrl_parser u_parser (
        .clk    (clk),
        .rst_n  (rst_n),
        .c_s    (c_s),
        .c_m    (c_m),
        .act_wr (act_wr)
    );

endmodule

`default_nettype wire

// ==== design/lke_ctrl_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module lke_ctrl_parser (
    input  logic                clk,
    input  logic                rst_n,
    input  lke_pkg::ctrl_beat_t c_s,
    output lke_pkg::ctrl_beat_t c_m,
    output lke_pkg::act_wr_t    act_wr
);

    import lke_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_parse,
        st_entry_1,
        st_entry_2,
        st_entry_3,
        st_flush
    } ctrl_state_t;

    ctrl_state_t            state;
    ctrl_beat_t             first_q;
    ctrl_beat_t             beat_d1;
    ctrl_seg_u              seg;
    logic [ctrl_data_w-1:0] swapped;
    logic                   is_write;

    assign seg.raw = c_s.data;

    // ==================================================
    // header decode and byte swap
    // ==================================================
    assign is_write = c_s.valid
                   && (seg.hdr.mod_id[7:3] == stage_id)
                   && (seg.hdr.mod_id[2:0] == lookup_id)
                   && (seg.hdr.control_flag == ctrl_magic)
                   && (seg.hdr.resv != 4'd0);

    // byte 0 lands in the top byte
    always_comb begin
        for (int i = 0; i < ctrl_data_w / 8; i++) begin
            swapped[ctrl_data_w-1-8*i -: 8] = seg.raw[8*i +: 8];
        end
    end

    // one cycle copy of the input for forwarding
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_d1 <= '0;
        end else begin
            beat_d1 <= c_s;
        end
    end

    // ==================================================
    // control FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            first_q <= '0;
            c_m     <= '0;
            act_wr  <= '0;
        end else begin
            c_m       <= '0;
            act_wr.en <= 1'b0;
            case (state)
                st_idle: begin
                    if (c_s.valid) begin
                        first_q <= c_s;
                        state   <= st_parse;
                    end
                end
                st_parse: begin
                    if (first_q.last) begin
                        // single segment packet, nothing to decode
                        c_m   <= first_q;
                        state <= st_idle;
                    end else if (is_write) begin
                        act_wr.addr <= seg.hdr.index[act_addr_w-1:0];
                        state       <= st_entry_1;
                    end else if (c_s.valid) begin
                        c_m   <= first_q;
                        state <= st_flush;
                    end
                end
                st_entry_1: begin
                    if (c_s.valid) begin
                        act_wr.data[act_len-1 -: ctrl_data_w] <= swapped;
                        state <= st_entry_2;
                    end
                end
                st_entry_2: begin
                    if (c_s.valid) begin
                        act_wr.data[tail_bits+ctrl_data_w-1 -: ctrl_data_w] <= swapped;
                        state <= st_entry_3;
                    end
                end
                st_entry_3: begin
                    if (c_s.valid) begin
                        act_wr.data[tail_bits-1:0] <= swapped[ctrl_data_w-1 -: tail_bits];
                        act_wr.en <= 1'b1;
                        state     <= st_idle;
                    end
                end
                st_flush: begin
                    c_m <= beat_d1;
                    if (beat_d1.valid && beat_d1.last) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/lke_phv_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module lke_phv_pipe (
    input  logic                clk,
    input  logic                rst_n,
    input  lke_pkg::phv_t       phv_in,
    input  logic                phv_valid,
    input  logic                if_match,
    input  lke_pkg::act_entry_t rd_data,
    input  logic                ready_in,
    output logic                ready_out,
    output lke_pkg::act_entry_t action,
    output logic                action_valid,
    output lke_pkg::phv_t       phv_out
);

    import lke_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_halt
    } pipe_state_t;

    pipe_state_t state;
    phv_t        phv_q;
    act_entry_t  act_q;
    act_entry_t  act_sel;
    logic        hit_q;

    // table read data is valid one cycle after capture
    assign act_sel   = hit_q ? rd_data : default_action;
    assign ready_out = (state != st_halt);

    always_ff @(posedge clk) begin
        if (state == st_idle && phv_valid) begin
            phv_q <= phv_in;
        end
        // keep the action while the engine stalls
        if (state == st_wait) begin
            act_q <= act_sel;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            hit_q        <= 1'b0;
            action_valid <= 1'b0;
            action       <= '0;
            phv_out      <= '0;
        end else begin
            action_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (phv_valid) begin
                        hit_q <= if_match;
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (ready_in) begin
                        action       <= act_sel;
                        phv_out      <= phv_q;
                        action_valid <= 1'b1;
                        state        <= st_idle;
                    end else begin
                        state <= st_halt;
                    end
                end
                st_halt: begin
                    if (ready_in) begin
                        action       <= act_q;
                        phv_out      <= phv_q;
                        action_valid <= 1'b1;
                        state        <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/lke_action_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lke_action_ram (
    input  logic                            clk,
    input  lke_pkg::act_wr_t                act_wr,
    input  logic [lke_pkg::act_addr_w-1:0]  rd_addr,
    output lke_pkg::act_entry_t             rd_data
);

    import lke_pkg::*;

    act_entry_t mem [act_depth];

    // write port from the control path
    always_ff @(posedge clk) begin
        if (act_wr.en) begin
            mem[act_wr.addr] <= act_wr.data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== design/lke_pkg.sv ====
`default_nettype none

package lke_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int phv_len     = 1024;
    localparam int act_len     = 625;
    localparam int act_depth   = 16;
    localparam int act_addr_w  = 4;
    localparam int ctrl_data_w = 256;
    localparam int ctrl_user_w = 128;
    localparam int ctrl_keep_w = 32;
    // last slice of an action entry
    localparam int tail_bits   = 113;

    // ==================================================
    // control header constants
    // ==================================================
    localparam logic [4:0]  stage_id   = 5'd0;
    localparam logic [2:0]  lookup_id  = 3'd2;
    localparam logic [15:0] ctrl_magic = 16'hf2f1;

    typedef logic [phv_len-1:0] phv_t;
    typedef logic [act_len-1:0] act_entry_t;

    // action on a table miss
    localparam act_entry_t default_action = act_entry_t'(8'h3f);

    typedef struct packed {
        logic [ctrl_data_w-1:0] data;
        logic [ctrl_user_w-1:0] user;
        logic [ctrl_keep_w-1:0] keep;
        logic                   last;
        logic                   valid;
    } ctrl_beat_t;

    // header segment, declared msb first
    typedef struct packed {
        logic [119:0] pad_hi;
        logic [7:0]   index;
        logic [3:0]   pad_idx;
        logic [3:0]   resv;
        logic [7:0]   mod_id;
        logic [31:0]  pad_mod;
        logic [15:0]  control_flag;
        logic [63:0]  pad_lo;
    } ctrl_hdr_t;

    typedef union packed {
        logic [ctrl_data_w-1:0] raw;
        ctrl_hdr_t              hdr;
    } ctrl_seg_u;

    typedef struct packed {
        logic                  en;
        logic [act_addr_w-1:0] addr;
        act_entry_t            data;
    } act_wr_t;

endpackage

`default_nettype wire
